/* verilog/icache_pkg.sv */
// geometry is fixed at 2 ways x 64 sets x 16 byte lines and the address split relies on it
`default_nettype none

package icache_pkg;

  // address split is tag | index | offset
  localparam int addr_w         = 32;
  localparam int data_w         = 64;   // fetch word and memory beat
  localparam int line_w         = 128;
  localparam int tag_w          = 22;
  localparam int index_w        = 6;
  localparam int offset_w       = 4;    // byte offset in a line
  localparam int num_ways       = 2;
  localparam int num_sets       = 64;
  localparam int beats_per_line = 2;

  typedef logic [$clog2(num_ways)-1:0]       way_t;
  typedef logic [index_w-1:0]                index_t;
  typedef logic [tag_w-1:0]                  tag_t;
  typedef logic [data_w-1:0]                 word_t;
  typedef logic [line_w-1:0]                 line_t;
  typedef logic [$clog2(beats_per_line)-1:0] beat_t;  // beat number in a burst

  // bus response code
  typedef logic [1:0] resp_t;
  localparam resp_t resp_ok = 2'b00;  // anything else is an error

endpackage

`default_nettype wire

/* verilog/icache_tag_if.sv */
// lookup is combinational on the tag store arrays and fill_en and set_valid never overlap
`timescale 1ns/1ns
`default_nettype none

interface icache_tag_if;
  import icache_pkg::*;

  // lookup, driven by the controller
  index_t lookup_index;
  tag_t   lookup_tag;

  // lookup result
  logic   hit;
  way_t   hit_way;
  way_t   victim_way;   // from the free-running counter

  // fill side
  logic   fill_en;      // invalidate entry and write new tag
  way_t   fill_way;
  index_t fill_index;
  tag_t   fill_tag;
  logic   set_valid;    // entry at fill_way/fill_index becomes valid

  modport ctrl (
    output lookup_index, lookup_tag, fill_en, fill_way, fill_index, fill_tag, set_valid,
    input  hit, hit_way, victim_way
  );

  modport store (
    input  lookup_index, lookup_tag, fill_en, fill_way, fill_index, fill_tag, set_valid,
    output hit, hit_way, victim_way
  );

endinterface

`default_nettype wire

/* verilog/icache_fill_if.sv */
// one beat write or one line read per cycle and rd_line follows rd_en by one cycle
`timescale 1ns/1ns
`default_nettype none

interface icache_fill_if;
  import icache_pkg::*;

  // half-line write
  logic   wr_en;
  way_t   wr_way;
  index_t wr_index;
  beat_t  wr_beat;    // selects the line half
  word_t  wr_data;

  // line read
  logic   rd_en;
  way_t   rd_way;
  index_t rd_index;
  line_t  rd_line;    // registered

  modport ctrl (
    output wr_en, wr_way, wr_index, wr_beat, wr_data, rd_en, rd_way, rd_index,
    input  rd_line
  );

  modport ram (
    input  wr_en, wr_way, wr_index, wr_beat, wr_data, rd_en, rd_way, rd_index,
    output rd_line
  );

endinterface

`default_nettype wire

/* verilog/icache_tag_store.sv */
// tags carry no reset so only the valid bits are trustworthy after rst
`timescale 1ns/1ns
`default_nettype none

module icache_tag_store (
  input wire          clk,
  input wire          rst,
  icache_tag_if.store tag
);
  import icache_pkg::*;

  tag_t                              tag_q [num_ways][num_sets];
  logic [num_ways-1:0][num_sets-1:0] valid_q;
  logic [num_ways-1:0]               hit_vec;
  way_t                              victim_q;

  // two-way compare
  always_comb begin
    tag.hit_way = '0;
    for (int w = 0; w < num_ways; w++) begin
      hit_vec[w] = valid_q[w][tag.lookup_index] &&
                   (tag_q[w][tag.lookup_index] == tag.lookup_tag);
      if (hit_vec[w]) begin
        tag.hit_way = way_t'(w);
      end
    end
  end

  assign tag.hit        = |hit_vec;
  assign tag.victim_way = victim_q;

  always_ff @(posedge clk) begin
    if (tag.fill_en) begin
      tag_q[tag.fill_way][tag.fill_index] <= tag.fill_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (tag.fill_en) begin
      valid_q[tag.fill_way][tag.fill_index] <= 1'b0;  // line is in flight
    end else if (tag.set_valid) begin
      valid_q[tag.fill_way][tag.fill_index] <= 1'b1;
    end
  end

  // pseudo-random replacement
  always_ff @(posedge clk) begin
    if (rst) begin
      victim_q <= '0;
    end else begin
      victim_q <= victim_q + 1'b1;
    end
  end

  // a line is only filled after missing in both ways
  a_single_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_vec));

endmodule

`default_nettype wire

/* verilog/icache_data_ram.sv */
// line data is undefined until filled and the controller never reads and writes together
`timescale 1ns/1ns
`default_nettype none

module icache_data_ram (
  input wire         clk,
  icache_fill_if.ram fill
);
  import icache_pkg::*;

  // one bank per way
  line_t mem_q [num_ways][num_sets];

  // a beat fills one half of the line
  always_ff @(posedge clk) begin
    if (fill.wr_en) begin
      mem_q[fill.wr_way][fill.wr_index][fill.wr_beat*data_w +: data_w] <= fill.wr_data;
    end
  end

  // synchronous read
  always_ff @(posedge clk) begin
    if (fill.rd_en) begin
      fill.rd_line <= mem_q[fill.rd_way][fill.rd_index];
    end
  end

  // writes only happen in the burst and reads only in the lookup state
  a_no_rw: assert property (@(posedge clk) !(fill.wr_en && fill.rd_en));

endmodule

`default_nettype wire

/* verilog/icache_ctrl.sv */
// one fetch in flight, bursts are exactly beats_per_line long and errors leave the line invalid
`timescale 1ns/1ns
`default_nettype none

module icache_ctrl (
  input  wire                      clk,
  input  wire                      rst,
  // fetch side
  input  wire                      req_valid_i,
  output logic                     req_ready_o,
  input  wire [icache_pkg::addr_w-1:0] req_addr_i,
  output logic                     rsp_valid_o,
  input  wire                      rsp_ready_i,
  output icache_pkg::word_t        rsp_data_o,
  output logic                     rsp_err_o,
  // memory side
  output logic                     mem_ar_valid_o,
  input  wire                      mem_ar_ready_i,
  output logic [icache_pkg::addr_w-1:0] mem_ar_addr_o,
  input  wire                      mem_r_valid_i,
  output logic                     mem_r_ready_o,
  input  wire icache_pkg::word_t   mem_r_data_i,
  input  wire icache_pkg::resp_t   mem_r_resp_i,
  input  wire                      mem_r_last_i,
  icache_tag_if.ctrl               tag,
  icache_fill_if.ctrl              fill
);
  import icache_pkg::*;

  typedef enum logic [2:0] {
    s_idle, s_lookup, s_read, s_resp, s_addr, s_burst
  } state_t;

  state_t            state_q;
  logic [addr_w-1:0] addr_q;      // latched fetch address
  way_t              way_q;       // victim for a miss
  beat_t             beat_q;
  logic              err_q;       // sticky over the burst
  word_t             rsp_data_q;

  index_t index_q;
  beat_t  req_beat;               // beat holding the requested word
  logic   r_fire;
  logic   last_beat;
  logic   beat_err;

  assign index_q   = addr_q[offset_w +: index_w];
  assign req_beat  = addr_q[offset_w-1 -: $bits(beat_t)];
  assign r_fire    = mem_r_valid_i && mem_r_ready_o;
  assign last_beat = (beat_q == beat_t'(beats_per_line - 1));
  assign beat_err  = (mem_r_resp_i != resp_ok);

  // tag store
  assign tag.lookup_index = index_q;
  assign tag.lookup_tag   = addr_q[addr_w-1 -: tag_w];
  assign tag.fill_en      = (state_q == s_lookup) && !tag.hit;
  assign tag.fill_way     = way_q;
  assign tag.fill_index   = index_q;
  assign tag.fill_tag     = addr_q[addr_w-1 -: tag_w];
  assign tag.set_valid    = r_fire && last_beat && !err_q && !beat_err;

  // data store
  assign fill.wr_en    = r_fire;
  assign fill.wr_way   = way_q;
  assign fill.wr_index = index_q;
  assign fill.wr_beat  = beat_q;
  assign fill.wr_data  = mem_r_data_i;
  assign fill.rd_en    = (state_q == s_lookup);
  assign fill.rd_way   = tag.hit_way;
  assign fill.rd_index = index_q;

  assign req_ready_o    = (state_q == s_idle);
  assign rsp_valid_o    = (state_q == s_resp);
  assign rsp_data_o     = rsp_data_q;
  assign rsp_err_o      = err_q;
  assign mem_ar_valid_o = (state_q == s_addr);
  assign mem_ar_addr_o  = {addr_q[addr_w-1:offset_w], {offset_w{1'b0}}};  // line aligned
  assign mem_r_ready_o  = (state_q == s_burst);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= s_idle;
      beat_q  <= '0;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        s_idle: if (req_valid_i) begin
          state_q <= s_lookup;
          beat_q  <= '0;
          err_q   <= 1'b0;
        end
        s_lookup: state_q <= tag.hit ? s_read : s_addr;
        s_read:   state_q <= s_resp;
        s_resp: if (rsp_ready_i) begin
          state_q <= s_idle;
        end
        s_addr: if (mem_ar_ready_i) begin
          state_q <= s_burst;
        end
        s_burst: if (r_fire) begin
          beat_q <= beat_q + 1'b1;
          err_q  <= err_q | beat_err;
          if (last_beat) begin
            state_q <= s_resp;
          end
        end
        default: state_q <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i && req_ready_o) begin
      addr_q <= req_addr_i;
      way_q  <= tag.victim_way;
    end
    if (state_q == s_read) begin
      rsp_data_q <= fill.rd_line[req_beat*data_w +: data_w];
    end else if (r_fire && beat_q == req_beat) begin
      rsp_data_q <= mem_r_data_i;  // forward the wanted beat
    end
  end

  a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
    rsp_valid_o && !rsp_ready_i |=> $stable(rsp_data_o) && $stable(rsp_err_o));

  // last has to match the beat count of the burst
  a_last_beat: assert property (@(posedge clk) disable iff (rst)
    r_fire |-> (mem_r_last_i == last_beat));

endmodule

`default_nettype wire

/* verilog/icache_top.sv */
// read-only cache, one outstanding fetch, memory must return aligned two-beat bursts
`timescale 1ns/1ns
`default_nettype none

module icache_top (
  input  wire                      clk,
  input  wire                      rst,
  // fetch request and response
  input  wire                      req_valid_i,
  output logic                     req_ready_o,
  input  wire [icache_pkg::addr_w-1:0] req_addr_i,
  output logic                     rsp_valid_o,
  input  wire                      rsp_ready_i,
  output icache_pkg::word_t        rsp_data_o,
  output logic                     rsp_err_o,
  // memory read address and data
  output logic                     mem_ar_valid_o,
  input  wire                      mem_ar_ready_i,
  output logic [icache_pkg::addr_w-1:0] mem_ar_addr_o,
  input  wire                      mem_r_valid_i,
  output logic                     mem_r_ready_o,
  input  wire icache_pkg::word_t   mem_r_data_i,
  input  wire icache_pkg::resp_t   mem_r_resp_i,
  input  wire                      mem_r_last_i
);

  icache_tag_if  tag_bus ();
  icache_fill_if fill_bus ();

  icache_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_addr_i     (req_addr_i),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i),
    .rsp_data_o     (rsp_data_o),
    .rsp_err_o      (rsp_err_o),
    .mem_ar_valid_o (mem_ar_valid_o),
    .mem_ar_ready_i (mem_ar_ready_i),
    .mem_ar_addr_o  (mem_ar_addr_o),
    .mem_r_valid_i  (mem_r_valid_i),
    .mem_r_ready_o  (mem_r_ready_o),
    .mem_r_data_i   (mem_r_data_i),
    .mem_r_resp_i   (mem_r_resp_i),
    .mem_r_last_i   (mem_r_last_i),
    .tag            (tag_bus.ctrl),
    .fill           (fill_bus.ctrl)
  );

  // tags, valid bits and victim choice
  icache_tag_store u_tag_store (
    .clk (clk),
    .rst (rst),
    .tag (tag_bus.store)
  );

  icache_data_ram u_data_ram (
    .clk  (clk),
    .fill (fill_bus.ram)
  );

endmodule

`default_nettype wire

/* bench/icache_tb.sv */
// memory model serves one aligned burst at a time and the run is capped at 40 cycles per fetch
`timescale 1ns/1ns
`default_nettype none

module icache_tb;
  import icache_pkg::*;

  localparam int rand_fetches = 60;
  localparam int num_fetches  = 1 + 2 + rand_fetches + 6 + 3;
  localparam int max_cycles   = 40 * num_fetches;

  logic              clk = 1'b0;
  logic              rst;
  logic              req_valid_i;
  logic              req_ready_o;
  logic [addr_w-1:0] req_addr_i;
  logic              rsp_valid_o;
  logic              rsp_ready_i;
  word_t             rsp_data_o;
  logic              rsp_err_o;
  logic              mem_ar_valid_o;
  logic              mem_ar_ready_i;
  logic [addr_w-1:0] mem_ar_addr_o;
  logic              mem_r_valid_i;
  logic              mem_r_ready_o;
  word_t             mem_r_data_i;
  resp_t             mem_r_resp_i;
  logic              mem_r_last_i;

  int   burst_cnt = 0;
  logic fail_next_burst = 1'b0;   // memory answers the next burst with an error
  logic [addr_w-1:0] fetch_addr = '0;  // address of the fetch in flight
  int   cycle_cnt;
  int   check_cnt = 0;
  int   error_cnt = 0;
  int   test_cnt = 0;
  int   failed_tests = 0;
  int   test_err_start = 0;

  icache_top UUT (.*);

  always #5 clk = ~clk;

  task automatic wait_cycle();
    @(posedge clk);
    #1;
  endtask

  // memory contents, one word per 8-byte beat address
  function automatic word_t mem_word(input logic [addr_w-1:0] addr);
    logic [addr_w-1:0] a;
    a = {addr[addr_w-1:3], 3'b000};
    return {a ^ 32'h5bd1e995, (a * 32'h9e3779b1) ^ 32'hd08bd08b};
  endfunction

  task automatic check_word(input word_t got, input logic [addr_w-1:0] addr);
    word_t exp;
    exp = mem_word(addr);
    check_cnt++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: word for %h is %h, expected %h", $time, addr, got, exp);
      error_cnt++;
    end
  endtask

  task automatic check_err(input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: rsp_err_o is %b, expected %b", $time, got, exp);
      error_cnt++;
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      error_cnt++;
    end
  endtask

  task automatic check_addr(input string what, input logic [addr_w-1:0] got,
                            input logic [addr_w-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      error_cnt++;
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    check_cnt++;
    if (got != exp) begin
      $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      error_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (error_cnt == test_err_start) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      $display("test %0d %s: %0d errors", test_cnt, name, error_cnt - test_err_start);
      failed_tests++;
    end
    test_err_start = error_cnt;
  endtask

  // lat counts cycles from the request edge to rsp_valid_o
  task automatic fetch(input logic [addr_w-1:0] addr, input bit stall_rsp,
                       output word_t data, output logic err, output int lat);
    fetch_addr  = addr;
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    while (req_ready_o !== 1'b1) wait_cycle();
    wait_cycle();
    req_valid_i = 1'b0;
    req_addr_i  = $urandom;   // don't care without valid
    lat = 0;
    while (rsp_valid_o !== 1'b1) begin
      wait_cycle();
      lat++;
    end
    data = rsp_data_o;
    err  = rsp_err_o;
    rsp_ready_i = stall_rsp ? 1'($urandom_range(1, 0)) : 1'b1;
    while (!rsp_ready_i) begin
      wait_cycle();
      check_bit("rsp_valid_o while stalled", rsp_valid_o, 1'b1);
      if (rsp_data_o !== data || rsp_err_o !== err) begin
        $display("CHECK FAILED at %0t ns: response for %h changed while stalled", $time, addr);
        error_cnt++;
      end
      rsp_ready_i = 1'($urandom_range(1, 0));
    end
    wait_cycle();               // response taken
    rsp_ready_i = 1'b0;
    check_bit("req_ready_o after response", req_ready_o, 1'b1);
  endtask

  // memory model with a random wait before the data and between beats
  initial begin : memory_model
    logic [addr_w-1:0] line_addr;
    logic              bad;
    mem_ar_ready_i = 1'b0;
    mem_r_valid_i  = 1'b0;
    mem_r_data_i   = '0;
    mem_r_resp_i   = resp_ok;
    mem_r_last_i   = 1'b0;
    forever begin
      wait_cycle();
      if (mem_ar_valid_o === 1'b1) begin
        mem_ar_ready_i = 1'b1;
        line_addr      = mem_ar_addr_o;
        check_addr("mem_ar_addr_o", line_addr, fetch_addr & 32'hffff_fff0);  // 16-byte line
        wait_cycle();
        mem_ar_ready_i  = 1'b0;
        burst_cnt++;
        bad             = fail_next_burst;
        fail_next_burst = 1'b0;
        repeat ($urandom_range(3, 0)) wait_cycle();
        for (int b = 0; b < beats_per_line; b++) begin
          mem_r_valid_i = 1'b1;
          mem_r_data_i  = mem_word(line_addr + addr_w'(b * (data_w / 8)));
          mem_r_resp_i  = (bad && b == 0) ? 2'b10 : resp_ok;  // slave error
          mem_r_last_i  = (b == beats_per_line - 1);
          while (mem_r_ready_o !== 1'b1) wait_cycle();
          wait_cycle();
          mem_r_valid_i = 1'b0;
          mem_r_last_i  = 1'b0;
          mem_r_resp_i  = resp_ok;
          if (b < beats_per_line - 1) begin
            repeat ($urandom_range(1, 0)) wait_cycle();
          end
        end
      end
    end
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < max_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, a handshake never completed", cycle_cnt);
    $display("Some tests failed");
    $finish;
  end

  initial begin : main
    word_t             data;
    logic              err;
    int                lat;
    int                bursts;
    logic [addr_w-1:0] a;
    rst         = 1'b1;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    rsp_ready_i = 1'b0;
    void'($urandom(32'hd08b));
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    check_bit("req_ready_o", req_ready_o, 1'b1);
    check_bit("rsp_valid_o", rsp_valid_o, 1'b0);
    check_bit("mem_ar_valid_o", mem_ar_valid_o, 1'b0);
    check_bit("mem_r_ready_o", mem_r_ready_o, 1'b0);
    bursts = burst_cnt;
    fetch(32'h0000_0100, 1'b0, data, err, lat);
    check_count("bursts", burst_cnt - bursts, 1);
    check_err(err, 1'b0);
    check_word(data, 32'h0000_0100);
    end_test("reset and first miss");

    for (int i = 0; i < 2; i++) begin
      a = 32'h0000_0100 + addr_w'(i * 8);   // same word, then the other half
      bursts = burst_cnt;
      fetch(a, 1'b0, data, err, lat);
      check_count("bursts", burst_cnt - bursts, 0);
      check_count("hit latency", lat, 2);
      check_err(err, 1'b0);
      check_word(data, a);
    end
    end_test("hits on a filled line");

    for (int i = 0; i < rand_fetches; i++) begin
      a = 32'h0000_2000 | ($urandom_range(1023, 0) << 2);  // 4 KiB region forces evictions
      fetch(a, 1'b1, data, err, lat);
      check_err(err, 1'b0);
      check_word(data, a);
    end
    end_test("random fetches with stalls");

    // set 5 with tags one 1 KiB step apart
    for (int k = 0; k < 3; k++) begin
      a = 32'h0001_0050 + addr_w'(k * 1024);
      bursts = burst_cnt;
      fetch(a, 1'b0, data, err, lat);
      check_word(data, a);
      if (k == 2) begin
        check_count("bursts for third line", burst_cnt - bursts, 1);
      end
    end
    for (int k = 0; k < 3; k++) begin
      a = 32'h0001_0058 + addr_w'(k * 1024);
      fetch(a, 1'b1, data, err, lat);
      check_word(data, a);
    end
    end_test("three lines in one set");

    fail_next_burst = 1'b1;
    bursts = burst_cnt;
    fetch(32'h0002_0308, 1'b1, data, err, lat);
    check_count("bursts", burst_cnt - bursts, 1);
    check_err(err, 1'b1);
    bursts = burst_cnt;
    fetch(32'h0002_0308, 1'b0, data, err, lat);
    check_count("bursts after error", burst_cnt - bursts, 1);
    check_err(err, 1'b0);
    check_word(data, 32'h0002_0308);
    bursts = burst_cnt;
    fetch(32'h0002_0300, 1'b0, data, err, lat);
    check_count("bursts on refilled line", burst_cnt - bursts, 0);
    check_err(err, 1'b0);
    check_word(data, 32'h0002_0300);
    end_test("memory error response");

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             test_cnt, failed_tests, check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
verilog/icache_pkg.sv
verilog/icache_tag_if.sv
verilog/icache_fill_if.sv
verilog/icache_tag_store.sv
verilog/icache_data_ram.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
bench/icache_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the cache testbench with Verilator, runs it and looks for the pass line
set -e

verilator --binary --timing --assert -f sources.f --top-module icache_tb -o icache_sim

out=$(./obj_dir/icache_sim)
echo "$out"
echo "$out" | grep -qx "All tests passed"
